/* vlog.f */
+incdir+include
verilog/lsiq_pkg.sv
verilog/lsiq_entry.sv
verilog/lsiq_ctrl.sv
verilog/lsiq_issue.sv
verilog/lsiq_result_fifo.sv
verilog/lsiq_top.sv
test/lsiq_properties.sv
test/lsiq_checker.sv
test/lsiq_tb.sv

/* Bender.yml */
package:
  name: lsiq

export_include_dirs:
  - include

sources:
  - verilog/lsiq_pkg.sv
  - verilog/lsiq_entry.sv
  - verilog/lsiq_ctrl.sv
  - verilog/lsiq_issue.sv
  - verilog/lsiq_result_fifo.sv
  - verilog/lsiq_top.sv
  - target: test
    files:
      - test/lsiq_properties.sv
      - test/lsiq_checker.sv
      - test/lsiq_tb.sv

/* test/lsiq_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lsiq_settings.svh"

module lsiq_tb
    import lsiq_pkg::*;
;

    localparam int MAX_CYCLES = 6000; // about 400 instructions at 15 cycles each

    logic                            clk;
    logic                            rst_n_i;
    logic                            flush_i;
    iq_dispatch_t                    dispatch_i;
    logic                            dispatch_valid_i;
    logic                            dispatch_ready_o;
    lsu_req_t                        lsu_req_o;
    logic                            lsu_req_valid_o;
    logic                            lsu_req_ready_i;
    lsu_resp_t                       lsu_resp_i;
    logic                            lsu_resp_valid_i;
    logic                            lsu_resp_ready_o;
    cdb_t                            cdb_o;
    logic                            cdb_ready_i;
    cdb_t [`LSIQ_SNOOP_PORTS-1:0]    snoop_i;

    lsu_resp_t  resp_q[$];  // responses owed by the memory model
    rob_tag_t   wait_tag[$]; // tags still to be broadcast
    int         wait_dly[$];
    rob_tag_t   next_tag;
    bit         hold_req;
    bit         hold_cdb;
    bit         counting;
    int         resp_cnt;
    int         cycles;
    int         due;
    rob_tag_t   noise;

    lsiq_top i_dut (.*);

    lsiq_checker i_checker (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .dispatch_i       (dispatch_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_ready_o (dispatch_ready_o),
        .lsu_req_o        (lsu_req_o),
        .lsu_req_valid_o  (lsu_req_valid_o),
        .lsu_req_ready_i  (lsu_req_ready_i),
        .lsu_resp_i       (lsu_resp_i),
        .lsu_resp_valid_i (lsu_resp_valid_i),
        .lsu_resp_ready_o (lsu_resp_ready_o),
        .cdb_o            (cdb_o),
        .cdb_ready_i      (cdb_ready_i),
        .snoop_i          (snoop_i)
    );

    always #10 clk = !clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // memory unit model, one response per accepted request
    always @(posedge clk) begin
        if (flush_i) begin
            resp_q.delete();
        end else begin
            if (lsu_resp_valid_i && lsu_resp_ready_o) begin
                void'(resp_q.pop_front());
            end
            if (lsu_req_valid_o && lsu_req_ready_i) begin
                resp_q.push_back('{tag: rob_tag_t'($urandom), rdata: $urandom});
            end
        end
        if (resp_q.size() > 0 && $urandom % 4 != 0) begin
            lsu_resp_valid_i <= 1'b1;
            lsu_resp_i       <= resp_q[0];
        end else begin
            lsu_resp_valid_i <= 1'b0;
        end
        lsu_req_ready_i <= hold_req ? 1'b0 : ($urandom % 3 != 0);
        cdb_ready_i     <= hold_cdb ? 1'b0 : ($urandom % 4 != 0);
        if (counting && lsu_resp_valid_i && lsu_resp_ready_o) begin
            resp_cnt++;
        end
    end

    // producer results, port 1 carries the waited tags
    always @(posedge clk) begin
        due = -1;
        foreach (wait_dly[i]) begin
            if (wait_dly[i] > 0) begin
                wait_dly[i]--;
            end else if (due < 0) begin
                due = i;
            end
        end
        snoop_i[1].valid <= 1'b0;
        noise = rob_tag_t'($urandom);
        if (due >= 0) begin
            snoop_i[1] <= '{valid: 1'b1, tag: wait_tag[due], data: $urandom};
            if (noise == wait_tag[due]) begin
                noise = noise + 1'b1; // never the same tag on both ports
            end
            wait_tag.delete(due);
            wait_dly.delete(due);
        end
        snoop_i[0] <= '{valid: $urandom % 2, tag: noise, data: $urandom};
        if (dispatch_valid_i && dispatch_ready_o && !flush_i) begin
            for (int k = 0; k < 2; k++) begin
                if (!dispatch_i.operand[k].valid) begin
                    wait_tag.push_back(dispatch_i.operand[k].tag);
                    wait_dly.push_back(1 + $urandom % 12);
                end
            end
        end
    end

    function automatic iq_dispatch_t make_instr(input bit allow_wait);
        iq_dispatch_t d;
        d.payload.op.size      = mem_size_e'($urandom % 3);
        d.payload.op.is_signed = $urandom % 2;
        d.payload.op.write     = $urandom % 2;
        d.payload.offset       = $urandom;
        d.payload.dest         = rob_tag_t'($urandom);
        for (int k = 0; k < 2; k++) begin
            d.operand[k].data = $urandom;
            if (allow_wait && $urandom % 3 == 0) begin
                d.operand[k].valid = 1'b0;
                d.operand[k].tag   = next_tag;
                next_tag           = next_tag + 1'b1;
            end else begin
                d.operand[k].valid = 1'b1;
                d.operand[k].tag   = rob_tag_t'($urandom);
            end
        end
        return d;
    endfunction

    task automatic dispatch_one(input iq_dispatch_t d);
        if ($urandom % 4 == 0) begin
            dispatch_valid_i <= 1'b0; // idle gap
            @(posedge clk);
        end
        dispatch_i       <= d;
        dispatch_valid_i <= 1'b1;
        @(posedge clk);
        while (!dispatch_ready_o) begin
            @(posedge clk);
        end
    endtask

    task automatic run_random(input int n, input bit allow_wait);
        repeat (n) begin
            dispatch_one(make_instr(allow_wait));
        end
        dispatch_valid_i <= 1'b0;
    endtask

    // queues looked at mid-cycle, once every edge has settled
    task automatic wait_drain();
        dispatch_valid_i <= 1'b0;
        @(negedge clk);
        while (i_checker.pending() != 0 || resp_q.size() != 0 || lsu_resp_valid_i) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic do_flush();
        dispatch_valid_i <= 1'b0;
        flush_i          <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
    endtask

    task automatic fill_under_req_hold();
        int cnt;
        cnt      = 0;
        hold_req = 1'b1;
        repeat (2) @(posedge clk);
        dispatch_i       <= make_instr(1'b0);
        dispatch_valid_i <= 1'b1;
        repeat (20) begin
            @(posedge clk);
            if (dispatch_ready_o) begin
                cnt++;
                dispatch_i <= make_instr(1'b0);
            end
        end
        dispatch_valid_i <= 1'b0;
        i_checker.expect_count("dispatches accepted under request hold", cnt, `LSIQ_DEPTH + 1);
        hold_req = 1'b0;
        wait_drain();
    endtask

    task automatic fill_under_cdb_hold();
        hold_cdb = 1'b1;
        resp_cnt = 0;
        counting = 1'b1;
        repeat (20) begin
            dispatch_one(make_instr(1'b0));
        end
        dispatch_valid_i <= 1'b0;
        @(posedge clk);
        while (lsu_resp_ready_o) begin
            @(posedge clk);
        end
        counting = 1'b0;
        i_checker.expect_count("responses absorbed under result hold", resp_cnt,
                               `LSIQ_RESULT_DEPTH);
        hold_cdb = 1'b0;
        wait_drain();
    endtask

    initial begin
        void'($urandom(32'h27fb806e));
        clk              = 1'b0;
        rst_n_i          = 1'b0;
        flush_i          = 1'b0;
        dispatch_i       = '0;
        dispatch_valid_i = 1'b0;
        lsu_req_ready_i  = 1'b0;
        lsu_resp_i       = '0;
        lsu_resp_valid_i = 1'b0;
        cdb_ready_i      = 1'b0;
        snoop_i          = '0;
        next_tag         = '0;
        hold_req         = 1'b0;
        hold_cdb         = 1'b0;
        counting         = 1'b0;
        cycles           = 0;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        @(posedge clk);
        run_random(120, 1'b1);
        do_flush(); // drops whatever is in flight
        run_random(120, 1'b1);
        wait_drain();
        fill_under_req_hold();
        fill_under_cdb_hold();
        run_random(40, 1'b1);
        wait_drain();
        i_checker.report();
        if (i_checker.errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/lsiq_checker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lsiq_settings.svh"

module lsiq_checker
    import lsiq_pkg::*;
(
    input wire logic                           clk,
    input wire logic                           rst_n_i,
    input wire logic                           flush_i,
    input wire iq_dispatch_t                   dispatch_i,
    input wire logic                           dispatch_valid_i,
    input wire logic                           dispatch_ready_o,
    input wire lsu_req_t                       lsu_req_o,
    input wire logic                           lsu_req_valid_o,
    input wire logic                           lsu_req_ready_i,
    input wire lsu_resp_t                      lsu_resp_i,
    input wire logic                           lsu_resp_valid_i,
    input wire logic                           lsu_resp_ready_o,
    input wire cdb_t                           cdb_o,
    input wire logic                           cdb_ready_i,
    input wire cdb_t [`LSIQ_SNOOP_PORTS-1:0]   snoop_i
);

    iq_dispatch_t exp_q[$]; // instructions in dispatch order
    cdb_t         res_q[$];
    int           errors = 0;
    int           checks = 0;

    // expected request from the memory-type rules
    function automatic lsu_req_t ref_req(input iq_dispatch_t d);
        lsu_req_t r;
        int       lane;
        r.tag       = d.payload.dest;
        r.addr      = d.operand[0].data + 32'($signed(d.payload.offset));
        r.size      = d.payload.op.size;
        r.is_signed = d.payload.op.is_signed;
        r.write     = d.payload.op.write;
        case (d.payload.op.size)
            MEM_BYTE: begin
                lane   = r.addr % 4;
                r.strb = 4'b0001 << lane;
            end
            MEM_HALF: begin
                lane   = (r.addr % 4 >= 2) ? 2 : 0;
                r.strb = 4'b0011 << lane;
            end
            default: begin
                lane   = 0;
                r.strb = 4'b1111;
            end
        endcase
        r.wdata = d.operand[1].data << (8 * lane);
        if (!r.write) begin
            r.strb = 4'b0000;
        end
        return r;
    endfunction

    function automatic int pending();
        return exp_q.size() + res_q.size();
    endfunction

    task automatic expect_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report();
        $display("checker: %0d checks, %0d errors, %0d items left over",
                 checks, errors, pending());
    endtask

    always @(posedge clk or negedge rst_n_i) begin
        iq_dispatch_t d;
        lsu_req_t     exp;
        if (!rst_n_i || flush_i) begin
            exp_q.delete();
            res_q.delete();
        end else begin
            // waiting operands pick up broadcast data
            foreach (exp_q[i]) begin
                d = exp_q[i];
                for (int k = 0; k < 2; k++) begin
                    for (int p = 0; p < `LSIQ_SNOOP_PORTS; p++) begin
                        if (!d.operand[k].valid && snoop_i[p].valid &&
                            snoop_i[p].tag == d.operand[k].tag) begin
                            d.operand[k].valid = 1'b1;
                            d.operand[k].data  = snoop_i[p].data;
                        end
                    end
                end
                exp_q[i] = d;
            end
            if (lsu_req_valid_o && lsu_req_ready_i) begin
                checks++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("request accepted at %0t with no instruction outstanding", $time);
                end else begin
                    d   = exp_q.pop_front();
                    exp = ref_req(d);
                    if (!d.operand[0].valid || !d.operand[1].valid) begin
                        errors++;
                        $display("[ERROR] %0t: request issued before its operands", $time);
                    end else if (lsu_req_o !== exp) begin
                        errors++;
                        $display("[ERROR] %0t: request %h, expected %h", $time, lsu_req_o, exp);
                    end
                end
            end
            if (dispatch_valid_i && dispatch_ready_o) begin
                exp_q.push_back(dispatch_i);
            end
            if (cdb_o.valid && cdb_ready_i) begin
                checks++;
                if (res_q.size() == 0) begin
                    errors++;
                    $display("result at %0t with no response outstanding", $time);
                end else if (cdb_o !== res_q[0]) begin
                    errors++;
                    $display("[ERROR] %0t: result %h, expected %h", $time, cdb_o, res_q[0]);
                    void'(res_q.pop_front());
                end else begin
                    void'(res_q.pop_front());
                end
            end
            if (lsu_resp_valid_i && lsu_resp_ready_o) begin
                res_q.push_back('{valid: 1'b1, tag: lsu_resp_i.tag, data: lsu_resp_i.rdata});
            end
        end
    end

endmodule

`default_nettype wire

/* test/lsiq_properties.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lsiq_settings.svh"

module lsiq_properties
    import lsiq_pkg::*;
(
    input wire logic                              clk,
    input wire logic                              rst_n_i,
    input wire logic                              flush_i,
    input wire logic                              dispatch_ready_o,
    input wire lsu_req_t                          lsu_req_o,
    input wire logic                              lsu_req_valid_o,
    input wire logic                              lsu_req_ready_i,
    input wire logic                              lsu_resp_valid_i,
    input wire logic                              lsu_resp_ready_o,
    input wire cdb_t                              cdb_o,
    input wire logic                              cdb_ready_i
);

    // results buffered, seen from the two handshakes
    logic [$clog2(`LSIQ_RESULT_DEPTH):0] held;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            held <= '0;
        end else if (flush_i) begin
            held <= '0;
        end else begin
            held <= held + (lsu_resp_valid_i && lsu_resp_ready_o)
                         - (cdb_o.valid && cdb_ready_i);
        end
    end

    // held request must not move
    req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        lsu_req_valid_o && !lsu_req_ready_i && !flush_i |=>
        lsu_req_valid_o && $stable(lsu_req_o))
        else $error("request changed under back-pressure");

    after_flush: assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |=> dispatch_ready_o && !lsu_req_valid_o && !cdb_o.valid)
        else $error("outputs not idle after flush");

    after_reset: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(rst_n_i) |-> dispatch_ready_o && !lsu_req_valid_o && !cdb_o.valid)
        else $error("outputs not idle after reset");

    resp_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
        held < `LSIQ_RESULT_DEPTH |-> lsu_resp_ready_o)
        else $error("response ready low with room in the FIFO");

endmodule

bind lsiq_top lsiq_properties i_props (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .flush_i          (flush_i),
    .dispatch_ready_o (dispatch_ready_o),
    .lsu_req_o        (lsu_req_o),
    .lsu_req_valid_o  (lsu_req_valid_o),
    .lsu_req_ready_i  (lsu_req_ready_i),
    .lsu_resp_valid_i (lsu_resp_valid_i),
    .lsu_resp_ready_o (lsu_resp_ready_o),
    .cdb_o            (cdb_o),
    .cdb_ready_i      (cdb_ready_i)
);

`default_nettype wire

/* verilog/lsiq_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lsiq_settings.svh"

module lsiq_top
    import lsiq_pkg::*;
(
    input  wire logic                           clk,
    input  wire logic                           rst_n_i,
    input  wire logic                           flush_i,
    input  wire iq_dispatch_t                   dispatch_i,
    input  wire logic                           dispatch_valid_i,
    output logic                                dispatch_ready_o,
    output lsu_req_t                            lsu_req_o,
    output logic                                lsu_req_valid_o,
    input  wire logic                           lsu_req_ready_i,
    input  wire lsu_resp_t                      lsu_resp_i,
    input  wire logic                           lsu_resp_valid_i,
    output logic                                lsu_resp_ready_o,
    output cdb_t                                cdb_o,
    input  wire logic                           cdb_ready_i,
    input  wire cdb_t [`LSIQ_SNOOP_PORTS-1:0]   snoop_i
);

    logic [`LSIQ_DEPTH-1:0]             write_sel;
    logic [`LSIQ_DEPTH-1:0]             issue_sel;
    logic [`LSIQ_DEPTH-1:0]             entry_ready;
    iq_payload_t [`LSIQ_DEPTH-1:0]      entry_payload;
    word_t [`LSIQ_DEPTH-1:0][1:0]       entry_operand;
    iq_idx_t                            oldest;
    logic                               issue_fire;

    lsiq_ctrl u_ctrl (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .dispatch_valid_i (dispatch_valid_i),
        .issue_fire_i     (issue_fire),
        .dispatch_ready_o (dispatch_ready_o),
        .write_sel_o      (write_sel),
        .issue_sel_o      (issue_sel),
        .oldest_o         (oldest)
    );

    for (genvar i = 0; i < `LSIQ_DEPTH; i++) begin : g_entry
        lsiq_entry u_entry (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .flush_i    (flush_i),
            .write_i    (write_sel[i]),
            .dispatch_i (dispatch_i),
            .issue_i    (issue_sel[i]),
            .snoop_i    (snoop_i),
            .empty_o    (),
            .ready_o    (entry_ready[i]),
            .payload_o  (entry_payload[i]),
            .operand_o  (entry_operand[i])
        );
    end

    lsiq_issue u_issue (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .entry_ready_i   (entry_ready),
        .payload_i       (entry_payload),
        .operand_i       (entry_operand),
        .oldest_i        (oldest),
        .lsu_req_ready_i (lsu_req_ready_i),
        .issue_fire_o    (issue_fire),
        .lsu_req_o       (lsu_req_o),
        .lsu_req_valid_o (lsu_req_valid_o)
    );

    lsiq_result_fifo #(
        .DEPTH (`LSIQ_RESULT_DEPTH)
    ) u_result_fifo (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .lsu_resp_i       (lsu_resp_i),
        .lsu_resp_valid_i (lsu_resp_valid_i),
        .cdb_ready_i      (cdb_ready_i),
        .lsu_resp_ready_o (lsu_resp_ready_o),
        .cdb_o            (cdb_o)
    );

endmodule

`default_nettype wire

/* verilog/lsiq_result_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module lsiq_result_fifo
    import lsiq_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  wire logic        clk,
    input  wire logic        rst_n_i,
    input  wire logic        flush_i,
    input  wire lsu_resp_t   lsu_resp_i,
    input  wire logic        lsu_resp_valid_i,
    input  wire logic        cdb_ready_i,
    output logic             lsu_resp_ready_o,
    output cdb_t             cdb_o
);

    localparam int PTR_W = $clog2(DEPTH);

    lsu_resp_t          mem_q [DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [PTR_W:0]     count_q;
    logic               push;
    logic               pop;

    assign lsu_resp_ready_o = count_q != (PTR_W+1)'(DEPTH);
    assign push             = lsu_resp_valid_i && lsu_resp_ready_o;
    assign pop              = cdb_o.valid && cdb_ready_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + push - pop;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= lsu_resp_i;
        end
    end

    // head of the buffer straight onto the result bus
    assign cdb_o.valid = count_q != '0;
    assign cdb_o.tag   = mem_q[rd_ptr_q].tag;
    assign cdb_o.data  = mem_q[rd_ptr_q].rdata;

endmodule

`default_nettype wire

/* verilog/lsiq_issue.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lsiq_settings.svh"

module lsiq_issue
    import lsiq_pkg::*;
(
    input  wire logic                                   clk,
    input  wire logic                                   rst_n_i,
    input  wire logic                                   flush_i,
    input  wire logic [`LSIQ_DEPTH-1:0]                 entry_ready_i,
    input  wire iq_payload_t [`LSIQ_DEPTH-1:0]          payload_i,
    input  wire word_t [`LSIQ_DEPTH-1:0][1:0]           operand_i,
    input  wire iq_idx_t                                oldest_i,
    input  wire logic                                   lsu_req_ready_i,
    output logic                                        issue_fire_o,
    output lsu_req_t                                    lsu_req_o,
    output logic                                        lsu_req_valid_o
);

    logic         req_valid_q;
    logic         req_free;
    iq_payload_t  pay_q;
    word_t        base_q;
    word_t        sdata_q;

    word_t        addr;
    logic [3:0]   strb;
    word_t        wdata;

    // register empty or being drained this cycle
    assign req_free     = !req_valid_q || lsu_req_ready_i;
    // strictly in order, only the head slot may go
    assign issue_fire_o = entry_ready_i[oldest_i] && req_free && !flush_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_valid_q <= 1'b0;
        end else if (flush_i) begin
            req_valid_q <= 1'b0;
        end else if (req_free) begin
            req_valid_q <= issue_fire_o;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire_o) begin
            pay_q   <= payload_i[oldest_i];
            base_q  <= operand_i[oldest_i][0];
            sdata_q <= operand_i[oldest_i][1];
        end
    end

    assign addr = base_q + {{(32-`LSIQ_OFFSET_W){pay_q.offset[`LSIQ_OFFSET_W-1]}},
                            pay_q.offset};

    // byte lanes touched and data moved onto them
    always_comb begin
        case (pay_q.op.size)
            MEM_WORD: begin
                strb  = 4'b1111;
                wdata = sdata_q;
            end
            MEM_HALF: begin
                strb  = 4'b0011 << {addr[1], 1'b0};
                wdata = sdata_q << {addr[1], 4'd0};
            end
            default: begin
                strb  = 4'b0001 << addr[1:0];
                wdata = sdata_q << {addr[1:0], 3'd0};
            end
        endcase
        if (!pay_q.op.write) begin
            strb = 4'b0000; // loads write nothing
        end
    end

    always_comb begin
        lsu_req_o.tag       = pay_q.dest;
        lsu_req_o.addr      = addr;
        lsu_req_o.size      = pay_q.op.size;
        lsu_req_o.is_signed = pay_q.op.is_signed;
        lsu_req_o.write     = pay_q.op.write;
        lsu_req_o.strb      = strb;
        lsu_req_o.wdata     = wdata;
    end

    assign lsu_req_valid_o = req_valid_q;

endmodule

`default_nettype wire

/* verilog/lsiq_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lsiq_settings.svh"

module lsiq_ctrl
    import lsiq_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rst_n_i,
    input  wire logic                    flush_i,
    input  wire logic                    dispatch_valid_i,
    input  wire logic                    issue_fire_i,
    output logic                         dispatch_ready_o,
    output logic [`LSIQ_DEPTH-1:0]       write_sel_o,
    output logic [`LSIQ_DEPTH-1:0]       issue_sel_o,
    output iq_idx_t                      oldest_o
);

    localparam int CNT_W = $clog2(`LSIQ_DEPTH) + 1;

    iq_idx_t            wr_ptr_q;
    iq_idx_t            old_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic [CNT_W-1:0]   count_d;
    logic               xfer;

    assign xfer = dispatch_valid_i && dispatch_ready_o;

    // occupancy after this cycle's dispatch and issue
    always_comb begin
        count_d = count_q;
        if (xfer) begin
            count_d = count_d + 1'b1;
        end
        if (issue_fire_i) begin
            count_d = count_d - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q         <= '0;
            old_ptr_q        <= '0;
            count_q          <= '0;
            dispatch_ready_o <= 1'b1;
        end else if (flush_i) begin
            wr_ptr_q         <= '0;
            old_ptr_q        <= '0;
            count_q          <= '0;
            dispatch_ready_o <= 1'b1;
        end else begin
            if (xfer) begin
                wr_ptr_q <= wr_ptr_q + 1'b1; // wraps at depth
            end
            if (issue_fire_i) begin
                old_ptr_q <= old_ptr_q + 1'b1;
            end
            count_q          <= count_d;
            dispatch_ready_o <= count_d < CNT_W'(`LSIQ_DEPTH);
        end
    end

    always_comb begin
        for (int i = 0; i < `LSIQ_DEPTH; i++) begin
            write_sel_o[i] = xfer && (wr_ptr_q == iq_idx_t'(i));
            issue_sel_o[i] = issue_fire_i && (old_ptr_q == iq_idx_t'(i));
        end
    end

    assign oldest_o = old_ptr_q;

endmodule

`default_nettype wire

/* verilog/lsiq_entry.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lsiq_settings.svh"

module lsiq_entry
    import lsiq_pkg::*;
(
    input  wire logic                           clk,
    input  wire logic                           rst_n_i,
    input  wire logic                           flush_i,
    input  wire logic                           write_i,
    input  wire iq_dispatch_t                   dispatch_i,
    input  wire logic                           issue_i,
    input  wire cdb_t [`LSIQ_SNOOP_PORTS-1:0]   snoop_i,
    output logic                                empty_o,
    output logic                                ready_o,
    output iq_payload_t                         payload_o,
    output word_t [1:0]                         operand_o
);

    logic             busy_q;
    logic [1:0]       op_valid_q;
    rob_tag_t [1:0]   op_tag_q;
    word_t [1:0]      op_data_q;
    iq_payload_t      payload_q;

    logic [1:0]       hit;
    word_t [1:0]      hit_data;

    // tag match against every live snoop port
    always_comb begin
        hit      = '0;
        hit_data = op_data_q;
        for (int k = 0; k < 2; k++) begin
            for (int p = 0; p < `LSIQ_SNOOP_PORTS; p++) begin
                if (busy_q && !op_valid_q[k] && snoop_i[p].valid &&
                    snoop_i[p].tag == op_tag_q[k]) begin
                    hit[k]      = 1'b1;
                    hit_data[k] = snoop_i[p].data;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q     <= 1'b0;
            op_valid_q <= '0;
        end else begin
            if (flush_i || issue_i) begin
                busy_q <= 1'b0;
            end else if (write_i) begin
                busy_q <= 1'b1;
            end
            for (int k = 0; k < 2; k++) begin
                if (write_i) begin
                    op_valid_q[k] <= dispatch_i.operand[k].valid;
                end else if (hit[k]) begin
                    op_valid_q[k] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_i) begin
            payload_q <= dispatch_i.payload;
            for (int k = 0; k < 2; k++) begin
                op_tag_q[k]  <= dispatch_i.operand[k].tag;
                op_data_q[k] <= dispatch_i.operand[k].data;
            end
        end else begin
            op_data_q <= hit_data; // unchanged unless a port matched
        end
    end

    assign empty_o   = !busy_q;
    assign ready_o   = busy_q && (&op_valid_q);
    assign payload_o = payload_q;
    assign operand_o = op_data_q;

endmodule

`default_nettype wire

/* verilog/lsiq_pkg.sv */
`default_nettype none

`include "lsiq_settings.svh"

package lsiq_pkg;

    typedef logic [31:0] word_t;
    typedef logic [`LSIQ_TAG_W-1:0] rob_tag_t;

    // slot index inside the ring
    typedef logic [$clog2(`LSIQ_DEPTH)-1:0] iq_idx_t;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    typedef struct packed {
        mem_size_e size;
        logic      is_signed; // sign-extend on load
        logic      write;     // store when set
    } mem_op_t;

    typedef struct packed {
        logic     valid; // data present, tag no longer needed
        rob_tag_t tag;
        word_t    data;
    } operand_t;

    // everything an entry keeps besides its operands
    typedef struct packed {
        mem_op_t                   op;
        logic [`LSIQ_OFFSET_W-1:0] offset;
        rob_tag_t                  dest;
    } iq_payload_t;

    typedef struct packed {
        iq_payload_t    payload;
        operand_t [1:0] operand; // [0] base, [1] store data
    } iq_dispatch_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    data;
    } cdb_t;

    typedef struct packed {
        rob_tag_t   tag;
        word_t      addr;
        mem_size_e  size;
        logic       is_signed;
        logic       write;
        logic [3:0] strb;
        word_t      wdata;
    } lsu_req_t;

    typedef struct packed {
        rob_tag_t tag;
        word_t    rdata;
    } lsu_resp_t;

endpackage

`default_nettype wire

/* include/lsiq_settings.svh */
`ifndef LSIQ_SETTINGS_SVH
`define LSIQ_SETTINGS_SVH

// queue geometry

// number of queue entries, power of two
`define LSIQ_DEPTH 8

// width of a ROB tag
`define LSIQ_TAG_W 6

// result-bus ports watched by every entry
`define LSIQ_SNOOP_PORTS 2

// result side

// entries of the response FIFO toward the result bus
`define LSIQ_RESULT_DEPTH 16

// instruction fields

// signed immediate added to the base register
`define LSIQ_OFFSET_W 12

`endif
